// File: tilt_reader_params.svh
// Sensor commands, register addresses, SPI divider, frame sizing, tilt limits, digit patterns
`ifndef TILT_READER_PARAMS_SVH
`define TILT_READER_PARAMS_SVH

////////////////////////////////////////
// Sensor command bytes
////////////////////////////////////////
`define TR_CMD_WRITE        8'h0A  // Register write
`define TR_CMD_READ         8'h0B  // Register read

// Register map and data bytes
`define TR_ADDR_POWER       8'h2D  // Power control register
`define TR_VAL_MEASURE      8'h0A  // Measure mode wakes the part
`define TR_ADDR_SAMPLE      8'h0F  // Axis data register
`define TR_DUMMY_BYTE       8'h94  // Filler clocked out while reading

////////////////////////////////////////
// SPI framing
////////////////////////////////////////
`define TR_BYTES_PER_FRAME    3    // Command, address, data
`define TR_CLKS_PER_HALF_BIT  500  // 50 MHz system clock gives 50 kHz SCLK
`define TR_CS_INACTIVE_CLKS   1    // Extra idle clocks with CS high

// Tilt limits on the 4-bit magnitude
`define TR_TILT_THRESH      4'd2   // Positive side must exceed this
`define TR_TILT_THRESH_NEG  4'd14  // Negative side must stay under this

// Active-low digit patterns with segment g on bit 6
`define TR_SEG_0  7'h40
`define TR_SEG_1  7'h79
`define TR_SEG_2  7'h24

`endif

// File: tilt_pkg.sv
// Shared types for the SPI byte path, command sequencer, CS framing and tilt display
package tilt_pkg;

  typedef logic [7:0] byte_t;  // One SPI byte, MSB first on the wire
  typedef logic [6:0] seg_t;   // Active-low segments g..a

  ////////////////////////////////////////
  // Command sequencer states
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    SEQ_IDLE,        // Waiting for start level
    SEQ_SEND,        // tx_dv pulse on the bus
    SEQ_LOAD,        // Select next byte of the frame
    SEQ_WAIT_READY,  // Hold until engine takes a byte
    SEQ_WAIT_RX      // Last read byte out, wait for sample
  } seq_state_t;

  // Tilt direction codes shown on the digit
  typedef enum logic [1:0] {
    TILT_LEVEL = 2'd0,
    TILT_LEFT  = 2'd1,
    TILT_RIGHT = 2'd2
  } tilt_t;

  // Chip select framing
  typedef enum logic [1:0] {
    CS_IDLE,      // CS high, ready for a new frame
    CS_XFER,      // CS low while bytes remain
    CS_INACTIVE   // Forced gap between frames
  } cs_state_t;

endpackage

// File: spi_edge_timer.sv
// Half-bit divider making the mode 0 SPI clock and leading/trailing edge strobes for one byte
`timescale 1ns/1ns
`include "tilt_reader_params.svh"

module spi_edge_timer #(
  parameter int CLKS_PER_HALF_BIT = `TR_CLKS_PER_HALF_BIT  // 2 or more
) (
  input  logic i_Clk,
  input  logic i_Rst_L,
  input  logic i_start,    // One-cycle kick per byte
  output logic o_spi_clk,  // SCLK, idles low
  output logic o_lead,     // Rising SCLK strobe
  output logic o_trail,    // Falling SCLK strobe
  output logic o_busy      // Low only when no byte is in flight
);

  localparam int unsigned CW = $clog2(CLKS_PER_HALF_BIT * 2);
  localparam logic [CW-1:0] HALF_CNT = CW'(CLKS_PER_HALF_BIT - 1);
  localparam logic [CW-1:0] FULL_CNT = CW'(CLKS_PER_HALF_BIT * 2 - 1);

  logic [CW-1:0] r_clk_count;  // System clocks within one SPI bit
  logic [4:0]    r_edges;      // Edges left in this byte
  logic          r_spi_clk;    // Internal SCLK before alignment

  ////////////////////////////////////////
  // Edge generation
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_clk_count <= '0;
      r_edges     <= '0;
      r_spi_clk   <= 1'b0;
      o_lead      <= 1'b0;
      o_trail     <= 1'b0;
      o_busy      <= 1'b0;
    end
    else
    begin
      o_lead  <= 1'b0;  // Strobes are single cycle
      o_trail <= 1'b0;
      o_busy  <= i_start || (r_edges != 5'd0);
      if (i_start)
      begin
        r_edges     <= 5'd16;  // Eight bits, two edges each
        r_clk_count <= '0;
      end
      else if (r_edges != 5'd0)
      begin
        if (r_clk_count == FULL_CNT)
        begin
          r_edges     <= r_edges - 5'd1;
          r_clk_count <= '0;         // End of bit
          r_spi_clk   <= ~r_spi_clk; // Falls
          o_trail     <= 1'b1;
        end
        else if (r_clk_count == HALF_CNT)
        begin
          r_edges     <= r_edges - 5'd1;
          r_clk_count <= r_clk_count + 1'b1;
          r_spi_clk   <= ~r_spi_clk; // Rises
          o_lead      <= 1'b1;
        end
        else
        begin
          r_clk_count <= r_clk_count + 1'b1;
        end
      end
    end
  end

  // Extra stage so SCLK lines up with MOSI and the sampling strobe
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_spi_clk <= 1'b0;
    end
    else
    begin
      o_spi_clk <= r_spi_clk;
    end
  end

endmodule

// File: spi_byte_shifter.sv
// MOSI shift-out on trailing edges, MISO capture on leading edges, received-byte valid pulse
`timescale 1ns/1ns

module spi_byte_shifter (
  input  logic            i_Clk,
  input  logic            i_Rst_L,
  input  logic            i_tx_dv,    // Byte strobe from the sequencer
  input  tilt_pkg::byte_t i_tx_byte,
  input  logic            i_busy,     // Engine running
  input  logic            i_lead,     // Sample point
  input  logic            i_trail,    // Shift point
  input  logic            i_miso,
  output logic            o_mosi,
  output logic            o_rx_dv,    // One cycle after the 8th sample
  output tilt_pkg::byte_t o_rx_byte
);

  tilt_pkg::byte_t r_tx_byte;  // Held copy of the outgoing byte
  logic            r_tx_dv;    // tx_dv delayed one cycle
  logic [2:0]      r_tx_bit;   // Next bit for MOSI
  logic [2:0]      r_rx_bit;   // Next slot for MISO

  // Keep the byte locally since the sequencer may move on
  always_ff @(posedge i_Clk)
  begin
    if (i_tx_dv)
    begin
      r_tx_byte <= i_tx_byte;
    end
  end

  ////////////////////////////////////////
  // Transmit side
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_tx_dv  <= 1'b0;
      o_mosi   <= 1'b0;
      r_tx_bit <= 3'd7;
    end
    else
    begin
      r_tx_dv <= i_tx_dv;
      if (!i_busy)
      begin
        r_tx_bit <= 3'd7;            // Restart between bytes
      end
      else if (r_tx_dv)
      begin
        o_mosi   <= r_tx_byte[7];    // MSB ahead of first rising edge
        r_tx_bit <= 3'd6;
      end
      else if (i_trail)
      begin
        o_mosi   <= r_tx_byte[r_tx_bit];
        r_tx_bit <= r_tx_bit - 3'd1;
      end
    end
  end

  ////////////////////////////////////////
  // Receive side
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_rx_dv  <= 1'b0;
      r_rx_bit <= 3'd7;
    end
    else
    begin
      o_rx_dv <= 1'b0;
      if (!i_busy)
      begin
        r_rx_bit <= 3'd7;
      end
      else if (i_lead)
      begin
        r_rx_bit <= r_rx_bit - 3'd1;
        o_rx_dv  <= (r_rx_bit == 3'd0);  // LSB just landed
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (i_busy && i_lead)
    begin
      o_rx_byte[r_rx_bit] <= i_miso;
    end
  end

endmodule

// File: spi_cs_frame.sv
// Chip-select FSM holding CS low over a fixed byte count, inactive gap, transmit-ready
`timescale 1ns/1ns
`include "tilt_reader_params.svh"

module spi_cs_frame (
  input  logic i_Clk,
  input  logic i_Rst_L,
  input  logic i_tx_dv,     // Byte accepted this cycle
  input  logic i_busy,      // Byte engine running
  output logic o_tx_ready,  // Next tx_dv allowed
  output logic o_cs_n
);

  localparam int unsigned RW = $clog2(`TR_BYTES_PER_FRAME + 1);
  localparam int unsigned IW = $clog2(`TR_CS_INACTIVE_CLKS + 2);
  localparam logic [RW-1:0] FIRST_REM = RW'(`TR_BYTES_PER_FRAME - 1);
  localparam logic [IW-1:0] GAP_LOAD  = IW'(`TR_CS_INACTIVE_CLKS);

  tilt_pkg::cs_state_t r_state;
  logic [RW-1:0]       r_remain;    // Bytes still owed in this frame
  logic [IW-1:0]       r_inactive;  // Gap countdown

  ////////////////////////////////////////
  // CS state machine
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state    <= tilt_pkg::CS_IDLE;
      o_cs_n     <= 1'b1;  // Deselected
      r_remain   <= '0;
      r_inactive <= GAP_LOAD;
    end
    else
    begin
      case (r_state)
        tilt_pkg::CS_IDLE:
        begin
          if (i_tx_dv)  // First byte opens the frame
          begin
            r_remain <= FIRST_REM;
            o_cs_n   <= 1'b0;
            r_state  <= tilt_pkg::CS_XFER;
          end
        end
        tilt_pkg::CS_XFER:
        begin
          if (!i_busy)
          begin
            if (r_remain != '0)
            begin
              if (i_tx_dv)
              begin
                r_remain <= r_remain - 1'b1;
              end
            end
            else
            begin
              o_cs_n     <= 1'b1;  // Last byte done
              r_inactive <= GAP_LOAD;
              r_state    <= tilt_pkg::CS_INACTIVE;
            end
          end
        end
        tilt_pkg::CS_INACTIVE:
        begin
          if (r_inactive != '0)
          begin
            r_inactive <= r_inactive - 1'b1;
          end
          else
          begin
            r_state <= tilt_pkg::CS_IDLE;
          end
        end
        default:
        begin
          o_cs_n  <= 1'b1;
          r_state <= tilt_pkg::CS_IDLE;
        end
      endcase
    end
  end

  // Ready when a frame can open, or mid-frame between bytes
  assign o_tx_ready = ((r_state == tilt_pkg::CS_IDLE) ||
                       (r_state == tilt_pkg::CS_XFER && !i_busy && r_remain != '0)) &&
                      !i_tx_dv;

endmodule

// File: accel_sequencer.sv
// Command sequencer FSM sending the wake frame once, then read frames forever, with sample capture
`timescale 1ns/1ns
`include "tilt_reader_params.svh"

module accel_sequencer (
  input  logic            i_Clk,
  input  logic            i_Rst_L,
  input  logic            i_start,         // Level, held high to run
  input  logic            i_tx_ready,
  input  logic            i_rx_dv,
  input  tilt_pkg::byte_t i_rx_byte,
  output logic            o_tx_dv,         // One cycle per byte
  output tilt_pkg::byte_t o_tx_byte,
  output logic            o_sample_valid,  // One cycle with new sample
  output tilt_pkg::byte_t o_sample
);

  localparam logic [1:0] LAST_IDX = 2'(`TR_BYTES_PER_FRAME - 1);

  tilt_pkg::seq_state_t r_state;
  logic                 r_wake;        // High until the wake frame is out
  logic [1:0]           r_idx;         // Byte position being sent
  logic [1:0]           r_rx_cnt;      // Byte position being received
  logic                 w_sample_hit;  // Third byte of a read frame

  // Frame contents by frame type and byte position
  function automatic tilt_pkg::byte_t frame_byte(input logic wake, input logic [1:0] idx);
    tilt_pkg::byte_t b;
    case ({wake, idx})
      3'b100:  b = `TR_CMD_WRITE;
      3'b101:  b = `TR_ADDR_POWER;
      3'b110:  b = `TR_VAL_MEASURE;
      3'b000:  b = `TR_CMD_READ;
      3'b001:  b = `TR_ADDR_SAMPLE;
      default: b = `TR_DUMMY_BYTE;  // Clocks the data byte in
    endcase
    return b;
  endfunction

  assign w_sample_hit = (r_state == tilt_pkg::SEQ_WAIT_RX) && i_rx_dv && (r_rx_cnt == LAST_IDX);

  ////////////////////////////////////////
  // Byte sequencing
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state <= tilt_pkg::SEQ_IDLE;
      r_wake  <= 1'b1;
      r_idx   <= '0;
      o_tx_dv <= 1'b0;
    end
    else
    begin
      case (r_state)
        tilt_pkg::SEQ_IDLE:
        begin
          r_wake <= 1'b1;
          r_idx  <= '0;
          if (i_start)
          begin
            r_state <= tilt_pkg::SEQ_LOAD;
          end
        end
        tilt_pkg::SEQ_LOAD:
        begin
          r_state <= tilt_pkg::SEQ_WAIT_READY;  // tx_byte settles here
        end
        tilt_pkg::SEQ_WAIT_READY:
        begin
          if (i_tx_ready)
          begin
            o_tx_dv <= 1'b1;
            r_state <= tilt_pkg::SEQ_SEND;
          end
        end
        tilt_pkg::SEQ_SEND:
        begin
          o_tx_dv <= 1'b0;
          if (r_idx == LAST_IDX)
          begin
            r_idx  <= '0;
            r_wake <= 1'b0;  // Only reads from now on
            r_state <= r_wake ? tilt_pkg::SEQ_LOAD : tilt_pkg::SEQ_WAIT_RX;
          end
          else
          begin
            r_idx   <= r_idx + 2'd1;
            r_state <= tilt_pkg::SEQ_LOAD;
          end
        end
        tilt_pkg::SEQ_WAIT_RX:
        begin
          if (w_sample_hit)
          begin
            r_state <= tilt_pkg::SEQ_LOAD;  // Next read frame
          end
        end
        default:
        begin
          o_tx_dv <= 1'b0;
          r_state <= tilt_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (r_state == tilt_pkg::SEQ_LOAD)
    begin
      o_tx_byte <= frame_byte(r_wake, r_idx);
    end
  end

  ////////////////////////////////////////
  // Receive count and sample capture
  ////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_rx_cnt       <= '0;
      o_sample_valid <= 1'b0;
    end
    else
    begin
      o_sample_valid <= w_sample_hit;
      if (r_state == tilt_pkg::SEQ_IDLE)
      begin
        r_rx_cnt <= '0;
      end
      else if (i_rx_dv)
      begin
        r_rx_cnt <= (r_rx_cnt == LAST_IDX) ? 2'd0 : r_rx_cnt + 2'd1;  // Wraps each frame
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (w_sample_hit)
    begin
      o_sample <= i_rx_byte;
    end
  end

endmodule

// File: tilt_display.sv
// Registered sign/magnitude tilt classifier and seven-segment decode for digits 0 to 2
`timescale 1ns/1ns
`include "tilt_reader_params.svh"

module tilt_display (
  input  logic            i_Clk,
  input  logic            i_Rst_L,
  input  logic            i_sample_valid,
  input  tilt_pkg::byte_t i_sample,
  output tilt_pkg::tilt_t o_turn,
  output tilt_pkg::seg_t  o_hex0
);

  logic            w_sign;  // Bit 7 of the sample
  logic [3:0]      w_mag;   // Low nibble only
  tilt_pkg::tilt_t w_dir;

  assign w_sign = i_sample[7];
  assign w_mag  = i_sample[3:0];

  // Small positive is level, small negative nibble reads high
  always_comb
  begin
    w_dir = tilt_pkg::TILT_LEVEL;
    if (!w_sign && (w_mag > `TR_TILT_THRESH))
    begin
      w_dir = tilt_pkg::TILT_RIGHT;
    end
    else if (w_sign && (w_mag < `TR_TILT_THRESH_NEG))
    begin
      w_dir = tilt_pkg::TILT_LEFT;
    end
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_turn <= tilt_pkg::TILT_LEVEL;
    end
    else if (i_sample_valid)
    begin
      o_turn <= w_dir;  // Held until the next sample
    end
  end

  // Digit follows the registered code
  always_comb
  begin
    case (o_turn)
      tilt_pkg::TILT_LEFT:  o_hex0 = `TR_SEG_1;
      tilt_pkg::TILT_RIGHT: o_hex0 = `TR_SEG_2;
      default:              o_hex0 = `TR_SEG_0;
    endcase
  end

endmodule

// File: tilt_reader.sv
// Top level joining the SPI edge timer, byte shifter, CS framing, sequencer and tilt display
`timescale 1ns/1ns
`include "tilt_reader_params.svh"

module tilt_reader #(
  parameter int CLKS_PER_HALF_BIT = `TR_CLKS_PER_HALF_BIT
) (
  input  logic            i_Clk,
  input  logic            i_Rst_L,
  input  logic            i_start,     // Start switch
  input  logic            i_spi_miso,
  output logic            o_spi_clk,
  output logic            o_spi_mosi,
  output logic            o_spi_cs_n,
  output tilt_pkg::tilt_t o_turn,      // Direction code
  output tilt_pkg::seg_t  o_hex0       // Digit for the code
);

  // Sequencer to engine
  logic            w_tx_dv;
  tilt_pkg::byte_t w_tx_byte;
  logic            w_tx_ready;

  // Inside the byte engine
  logic            w_busy;
  logic            w_lead;
  logic            w_trail;
  logic            w_rx_dv;
  tilt_pkg::byte_t w_rx_byte;

  // Sample path
  logic            w_sample_valid;
  tilt_pkg::byte_t w_sample;

  ////////////////////////////////////////
  // SPI engine
  ////////////////////////////////////////
  spi_edge_timer #(
    .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
  ) u_edge_timer (
    .i_Clk     (i_Clk),
    .i_Rst_L   (i_Rst_L),
    .i_start   (w_tx_dv),
    .o_spi_clk (o_spi_clk),
    .o_lead    (w_lead),
    .o_trail   (w_trail),
    .o_busy    (w_busy)
  );

  spi_byte_shifter u_shifter (
    .i_Clk     (i_Clk),
    .i_Rst_L   (i_Rst_L),
    .i_tx_dv   (w_tx_dv),
    .i_tx_byte (w_tx_byte),
    .i_busy    (w_busy),
    .i_lead    (w_lead),
    .i_trail   (w_trail),
    .i_miso    (i_spi_miso),
    .o_mosi    (o_spi_mosi),
    .o_rx_dv   (w_rx_dv),
    .o_rx_byte (w_rx_byte)
  );

  spi_cs_frame u_cs_frame (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx_dv    (w_tx_dv),
    .i_busy     (w_busy),
    .o_tx_ready (w_tx_ready),
    .o_cs_n     (o_spi_cs_n)
  );

  // Command flow and readout
  accel_sequencer u_sequencer (
    .i_Clk          (i_Clk),
    .i_Rst_L        (i_Rst_L),
    .i_start        (i_start),
    .i_tx_ready     (w_tx_ready),
    .i_rx_dv        (w_rx_dv),
    .i_rx_byte      (w_rx_byte),
    .o_tx_dv        (w_tx_dv),
    .o_tx_byte      (w_tx_byte),
    .o_sample_valid (w_sample_valid),
    .o_sample       (w_sample)
  );

  tilt_display u_display (
    .i_Clk          (i_Clk),
    .i_Rst_L        (i_Rst_L),
    .i_sample_valid (w_sample_valid),
    .i_sample       (w_sample),
    .o_turn         (o_turn),
    .o_hex0         (o_hex0)
  );

endmodule

// File: tilt_reader_assert.sv
// Concurrent checks on tilt_reader ports: SCLK idle under CS high, direction range, digit patterns
`timescale 1ns/1ns
`include "tilt_reader_params.svh"

module tilt_reader_assert (
  input logic            i_Clk,
  input logic            i_Rst_L,
  input logic            i_spi_clk,   // DUT o_spi_clk
  input logic            i_spi_cs_n,  // DUT o_spi_cs_n
  input tilt_pkg::tilt_t i_turn,      // DUT o_turn
  input tilt_pkg::seg_t  i_hex0       // DUT o_hex0
);

  int unsigned fail_count = 0;  // Failed assertion attempts

  ////////////////////////////////////////
  // Bus idle rule
  ////////////////////////////////////////
  // Mode 0 clock rests low whenever the sensor is deselected
  a_sclk_idle: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_spi_cs_n |-> !i_spi_clk)
    else
    begin
      fail_count = fail_count + 1;
      $error("SCLK high while CS is high");
    end

  ////////////////////////////////////////
  // Display outputs
  ////////////////////////////////////////
  a_turn_range: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    2'(i_turn) != 2'd3)  // Code 3 is unused
    else
    begin
      fail_count = fail_count + 1;
      $error("Direction code 3 on o_turn");
    end

  // Only digits 0, 1 and 2 can be shown
  a_hex_pattern: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_hex0 inside {`TR_SEG_0, `TR_SEG_1, `TR_SEG_2})
    else
    begin
      fail_count = fail_count + 1;
      $error("Unknown segment pattern 0x%02h on o_hex0", i_hex0);
    end

endmodule

// File: tilt_reader_tb.sv
// Testbench for tilt_reader: clock, reset, SPI slave model, random samples, tilt model, watchdog
`timescale 1ns/1ns

module tilt_reader_tb;

  localparam int CLK_PERIOD   = 8;            // ns
  localparam int CPHB         = 4;            // Half-bit divider for the DUT
  localparam int RESET_CYCLES = 3;
  localparam int IDLE_CYCLES  = 50;           // Start held low this long
  localparam int READ_FRAMES  = 30;
  localparam int TOTAL_FRAMES = READ_FRAMES + 1;  // Wake frame comes first
  localparam int BYTE_CYCLES  = 16 * CPHB + 8;    // 16 SCLK edges plus handshake slack
  localparam int FRAME_CYCLES = 3 * BYTE_CYCLES;
  localparam longint WATCHDOG_NS =
    longint'(RESET_CYCLES + IDLE_CYCLES) * CLK_PERIOD +
    longint'(TOTAL_FRAMES) * FRAME_CYCLES * CLK_PERIOD * 2;  // Twice the expected run
  localparam logic [31:0] SEED = 32'he3097073;

  // DUT ports
  logic            i_Clk;
  logic            i_Rst_L;
  logic            i_start;
  logic            i_spi_miso;
  logic            o_spi_clk;
  logic            o_spi_mosi;
  logic            o_spi_cs_n;
  tilt_pkg::tilt_t o_turn;
  tilt_pkg::seg_t  o_hex0;

  // SPI slave model state
  logic        prev_sclk;
  logic        prev_cs_n;
  logic [7:0]  mosi_sr;        // Bits seen on MOSI
  logic [7:0]  miso_sr;        // Bits still to send on MISO
  int          bit_cnt;
  int          byte_cnt;
  logic [7:0]  mosi_bytes[$];  // Whole bytes of the current frame
  logic [7:0]  last_sample;    // Data byte returned in this read frame
  logic        sample_sent;
  int unsigned seed_ret;

  int frames_done = 0;
  int idle_errs   = 0;
  int frame_errs  = 0;
  int tilt_errs   = 0;
  int assert_errs = 0;
  int total_errs  = 0;

  ////////////////////////////////////////
  // DUT and assertions
  ////////////////////////////////////////
  tilt_reader #(
    .CLKS_PER_HALF_BIT (CPHB)
  ) u_tilt_reader (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_start    (i_start),
    .i_spi_miso (i_spi_miso),
    .o_spi_clk  (o_spi_clk),
    .o_spi_mosi (o_spi_mosi),
    .o_spi_cs_n (o_spi_cs_n),
    .o_turn     (o_turn),
    .o_hex0     (o_hex0)
  );

  bind tilt_reader tilt_reader_assert u_assert (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_spi_clk  (o_spi_clk),
    .i_spi_cs_n (o_spi_cs_n),
    .i_turn     (o_turn),
    .i_hex0     (o_hex0)
  );

  initial
  begin
    i_Clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_Clk = ~i_Clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  // Sign in bit 7 and magnitude in the low nibble
  function automatic logic [1:0] expected_tilt(input logic [7:0] b);
    logic [1:0] t;
    t = 2'd0;                                // Level
    if (!b[7] && (b[3:0] > 4'd2))
    begin
      t = 2'd2;                              // Right
    end
    else if (b[7] && (b[3:0] < 4'd14))
    begin
      t = 2'd1;                              // Left
    end
    return t;
  endfunction

  function automatic logic [6:0] expected_seg(input logic [1:0] t);
    logic [6:0] s;
    case (t)
      2'd1:    s = 7'h79;  // Digit 1
      2'd2:    s = 7'h24;  // Digit 2
      default: s = 7'h40;  // Digit 0
    endcase
    return s;
  endfunction

  // Wake frame then read frames, byte by byte
  function automatic logic [7:0] expected_frame_byte(input int frame, input int pos);
    logic [7:0] b;
    if (frame == 0)
    begin
      b = (pos == 1) ? 8'h2D : 8'h0A;
    end
    else
    begin
      case (pos)
        0:       b = 8'h0B;
        1:       b = 8'h0F;
        default: b = 8'h94;
      endcase
    end
    return b;
  endfunction

  // Every third sample gets a threshold magnitude and a sign that flips every four of them
  function automatic logic [7:0] draw_sample(input int k);
    logic [31:0] raw;
    logic [7:0]  b;
    int          idx;
    raw = $urandom;
    b   = raw[7:0];
    if (k % 3 == 0)
    begin
      idx = k / 3;
      case (idx % 4)
        0:       b[3:0] = 4'd2;
        1:       b[3:0] = 4'd3;
        2:       b[3:0] = 4'd13;
        default: b[3:0] = 4'd14;
      endcase
      b[7] = ((idx / 4) % 2) == 1;
    end
    return b;
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic check_idle();
    if (o_spi_cs_n !== 1'b1)
    begin
      $display("FAILED idle o_spi_cs_n: got 0x%0h expected 0x1", o_spi_cs_n);
      idle_errs++;
    end
    if (o_spi_clk !== 1'b0)
    begin
      $display("FAILED idle o_spi_clk: got 0x%0h expected 0x0", o_spi_clk);
      idle_errs++;
    end
    if (o_turn !== 2'd0)
    begin
      $display("FAILED idle o_turn: got 0x%0h expected 0x0", o_turn);
      idle_errs++;
    end
    if (o_hex0 !== 7'h40)
    begin
      $display("FAILED idle o_hex0: got 0x%02h expected 0x40", o_hex0);
      idle_errs++;
    end
  endtask

  // Runs at each CS rise on the bytes collected since CS fell
  task automatic check_frame(input int frame);
    logic [7:0] exp_b;
    logic [1:0] exp_t;
    logic [6:0] exp_seg;
    if ((mosi_bytes.size() != 3) || (bit_cnt != 0))
    begin
      $display("ERROR: frame %0d carried %0d whole bytes and %0d stray bits under one CS low",
               frame, mosi_bytes.size(), bit_cnt);
      frame_errs++;
    end
    for (int pos = 0; (pos < mosi_bytes.size()) && (pos < 3); pos++)
    begin
      exp_b = expected_frame_byte(frame, pos);
      if (mosi_bytes[pos] !== exp_b)
      begin
        $display("FAILED frame %0d byte %0d o_spi_mosi: got 0x%02h expected 0x%02h",
                 frame, pos, mosi_bytes[pos], exp_b);
        frame_errs++;
      end
    end
    if (frame > 0)
    begin
      if (!sample_sent)
      begin
        $display("ERROR: read frame %0d ended before the sample byte was sent", frame);
        tilt_errs++;
      end
      else
      begin
        exp_t   = expected_tilt(last_sample);
        exp_seg = expected_seg(exp_t);
        if (o_turn !== exp_t)
        begin
          $display("FAILED frame %0d o_turn: got 0x%0h expected 0x%0h (sample 0x%02h)",
                   frame, o_turn, exp_t, last_sample);
          tilt_errs++;
        end
        if (o_hex0 !== exp_seg)
        begin
          $display("FAILED frame %0d o_hex0: got 0x%02h expected 0x%02h (sample 0x%02h)",
                   frame, o_hex0, exp_seg, last_sample);
          tilt_errs++;
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // SPI slave model
  ////////////////////////////////////////
  // SCLK and CS edges are seen at the falling system clock where MISO also changes
  initial
  begin
    seed_ret    = $urandom(SEED);  // Seeds the thread that draws samples
    prev_sclk   = 1'b0;
    prev_cs_n   = 1'b1;
    mosi_sr     = 8'h00;
    miso_sr     = 8'h00;
    bit_cnt     = 0;
    byte_cnt    = 0;
    last_sample = 8'h00;
    sample_sent = 1'b0;
    i_spi_miso  = 1'b0;
    forever
    begin
      @(negedge i_Clk);
      if (i_Rst_L)
      begin
        if (prev_cs_n && !o_spi_cs_n)
        begin
          mosi_bytes.delete();             // Frame opens
          bit_cnt     = 0;
          byte_cnt    = 0;
          sample_sent = 1'b0;
          miso_sr     = 8'($urandom);      // Filler for the command byte
          i_spi_miso  = miso_sr[7];        // MSB ahead of first rising edge
        end
        else if (!prev_cs_n && o_spi_cs_n)
        begin
          check_frame(frames_done);
          frames_done++;
        end
        if (!o_spi_cs_n)
        begin
          if (!prev_sclk && o_spi_clk)     // Rising SCLK
          begin
            mosi_sr = {mosi_sr[6:0], o_spi_mosi};
            bit_cnt++;
            if (bit_cnt == 8)
            begin
              mosi_bytes.push_back(mosi_sr);
              bit_cnt = 0;
              byte_cnt++;
              if ((frames_done > 0) && (byte_cnt == 2))
              begin
                last_sample = draw_sample(frames_done - 1);  // Third byte of a read
                sample_sent = 1'b1;
                miso_sr     = last_sample;
              end
              else
              begin
                miso_sr = 8'($urandom);
              end
            end
            else
            begin
              miso_sr = {miso_sr[6:0], 1'b0};
            end
          end
          else if (prev_sclk && !o_spi_clk)  // Falling SCLK
          begin
            i_spi_miso = miso_sr[7];
          end
        end
        prev_sclk = o_spi_clk;
        prev_cs_n = o_spi_cs_n;
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial
  begin
    i_Rst_L = 1'b0;
    i_start = 1'b0;
    repeat (RESET_CYCLES) @(posedge i_Clk);
    @(negedge i_Clk);
    i_Rst_L = 1'b1;
    repeat (IDLE_CYCLES)               // Nothing may move before start
    begin
      @(negedge i_Clk);
      check_idle();
    end
    i_start = 1'b1;                    // Level, held for the rest of the run
    wait (frames_done == TOTAL_FRAMES);
    @(negedge i_Clk);
    assert_errs = int'(u_tilt_reader.u_assert.fail_count);
    total_errs  = idle_errs + frame_errs + tilt_errs + assert_errs;
    $display("Error counts: idle %0d, frame %0d, tilt %0d, assert %0d, total %0d",
             idle_errs, frame_errs, tilt_errs, assert_errs, total_errs);
    if (total_errs == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    assert_errs = int'(u_tilt_reader.u_assert.fail_count);
    total_errs  = idle_errs + frame_errs + tilt_errs + assert_errs + 1;
    $display("ERROR: timeout with %0d of %0d frames seen", frames_done, TOTAL_FRAMES);
    $display("Error counts: idle %0d, frame %0d, tilt %0d, assert %0d, total %0d",
             idle_errs, frame_errs, tilt_errs, assert_errs, total_errs);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: tilt_reader.f
+incdir+.
tilt_pkg.sv
spi_edge_timer.sv
spi_byte_shifter.sv
spi_cs_frame.sv
accel_sequencer.sv
tilt_display.sv
tilt_reader.sv
tilt_reader_assert.sv
tilt_reader_tb.sv
